// File: source/wave_geometry_pkg.sv
/*
	Alien wave geometry
	Screen limits, sprite sizes, speed thresholds and the coordinate
	types shared by the movers, renderers and the top level
*/
package wave_geometry_pkg;

	typedef logic [9:0] coord_t;        // Screen x or y
	typedef logic [9:0] sprite_addr_t;  // Room for both sprite frames
	typedef logic [2:0] alien_idx_t;    // Alien 0 to 6 within a row

	// Row layout
	localparam int ALIENS_PER_ROW = 7;
	localparam coord_t ALIEN_W = 10'd21;  // Sprite width in pixels
	localparam coord_t ALIEN_H = 10'd16;  // Sprite height in pixels
	localparam coord_t ALIEN_GAP = 10'd9;
	localparam coord_t ALIEN_PITCH = ALIEN_W + ALIEN_GAP;  // 30

	// Whole row width, no gap after the last alien
	localparam coord_t ROW_W = coord_t'(ALIENS_PER_ROW) * ALIEN_PITCH - ALIEN_GAP;

	// Horizontal playfield
	localparam coord_t X_START = 10'd170;
	localparam coord_t X_MIN = 10'd170;  // Left bounce point
	localparam coord_t X_MAX = 10'd478;  // Right screen edge of the field

	// Vertical motion
	localparam coord_t DESCEND = 10'd4;    // Drop at each side limit
	localparam coord_t LAND_Y = 10'd420;   // Row bottom at or below this has landed
	localparam coord_t SPEED2_Y = 10'd65;  // Above this y, 2 px per step
	localparam coord_t SPEED3_Y = 10'd240; // Above this y, 3 px per step

	// Arm animation
	// Edge columns swap to the arms-up frame
	localparam coord_t ARM_LEFT_COL = 10'd2;
	localparam coord_t ARM_RIGHT_COL = 10'd18;

	// One frame is 21 x 16 pixels
	localparam sprite_addr_t ARM_FRAME_OFS = sprite_addr_t'(ALIEN_W * ALIEN_H);

endpackage

// File: source/wave_types_pkg.sv
/*
	Alien wave signal types
	Game command encoding and the packed structs passed between
	the row movers, renderers and the top level
*/
package wave_types_pkg;

	// Pause, game over and win all map onto hold
	typedef enum logic [1:0] {
		wave_reset = 2'd0,  // Back to start positions
		wave_play  = 2'd1,  // Rows march on step pulses
		wave_hold  = 2'd2   // Rows frozen
	} wave_cmd_t;

	// Top left corner of a row, 20 bits
	typedef struct packed {
		wave_geometry_pkg::coord_t x;
		wave_geometry_pkg::coord_t y;
	} row_pos_t;

	// Result of the per-pixel hit test, 14 bits
	typedef struct packed {
		logic                            hit;    // Pixel lies on an alien
		wave_geometry_pkg::alien_idx_t   index;  // Which alien of the row
		wave_geometry_pkg::sprite_addr_t addr;   // Sprite memory address
	} alien_pixel_t;

endpackage

// File: source/frame_pacer.sv
/*
	Frame pacer
	Finds rising edges of the slow frame strobe, lets the rows step on
	every second frame and counts frames for the arm animation
*/
`timescale 1ns/1ps

module frame_pacer (
	input  logic Clk,
	input  logic arst_n,
	input  logic frame_clk,  // Slow frame strobe, about 60 Hz
	output logic step,       // One Clk pulse on odd frame edges
	output logic arm_up      // Arms-up sprite frame select
);

	logic       frame_q;     // Strobe sampled into the Clk domain
	logic       frame_prev;  // Previous sample for edge detect
	logic       frame_edge;  // One Clk pulse per strobe rise
	logic       go;          // Alternates every frame edge
	logic [4:0] frame_cnt;   // 32 frame animation period

	// Edge detect, pulse lands on the second Clk after the strobe rises
	always_ff @(posedge Clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			frame_q    <= 1'b0;
			frame_prev <= 1'b0;
			frame_edge <= 1'b0;
		end
		else
		begin
			frame_q    <= frame_clk;
			frame_prev <= frame_q;
			frame_edge <= frame_q & ~frame_prev;  // Low to high seen
		end
	end

	// Half-rate movement gate
	always_ff @(posedge Clk or negedge arst_n)
	begin
		if (!arst_n)
			go <= 1'b1;  // First edge after reset moves
		else if (frame_edge)
			go <= ~go;
	end

	// Animation counter
	always_ff @(posedge Clk or negedge arst_n)
	begin
		if (!arst_n)
			frame_cnt <= 5'd0;
		else if (frame_edge)
			frame_cnt <= frame_cnt + 5'd1;  // Wraps every 32 frames
	end

	assign step = frame_edge & go;
	assign arm_up = frame_cnt[4];  // Frames 16 to 31 show arms up

	// A step only ever rides a single-cycle edge pulse
	a_step_on_edge: assert property (
		@(posedge Clk) disable iff (!arst_n)
		step |-> frame_edge ##1 !frame_edge
	) else $error("step outside a single frame edge pulse");

endmodule

// File: source/row_mover.sv
/*
	Row mover
	Holds one row's position and marching direction, bounces and drops
	at the side limits, speeds up with height and stops on landing
*/
`timescale 1ns/1ps

module row_mover #(
	parameter wave_geometry_pkg::coord_t start_y = 10'd0  // Row start height
) (
	input  logic                    Clk,
	input  logic                    arst_n,
	input  wave_types_pkg::wave_cmd_t cmd,
	input  logic                    step,    // Advance request from the pacer
	output wave_types_pkg::row_pos_t  pos,     // Top left corner of the row
	output logic                    landed   // Row bottom reached the ground
);

	import wave_geometry_pkg::*;
	import wave_types_pkg::*;

	// Right bounce point for the left edge of the row
	localparam coord_t X_RIGHT_LIM = X_MAX - ROW_W;
	localparam coord_t X_LOW_BOUND = X_MIN - 10'd3;  // Worst overshoot at speed 3

	logic       move_right;       // Current direction with 1 for right
	logic       next_right;
	coord_t     speed;            // Pixels per step
	coord_t     next_x;
	coord_t     next_y;
	logic [10:0] row_bottom;      // One extra bit so the sum never wraps

	// Speed tier from the height before the step
	always_comb
	begin
		if (pos.y > SPEED3_Y)
			speed = 10'd3;
		else if (pos.y > SPEED2_Y)
			speed = 10'd2;
		else
			speed = 10'd1;
	end

	// Bounce and descent at the side limits, then move
	always_comb
	begin
		next_right = move_right;
		next_y = pos.y;
		if (pos.x >= X_RIGHT_LIM)
		begin
			next_y = pos.y + DESCEND;  // Drop and turn left
			next_right = 1'b0;
		end
		else if (pos.x <= X_MIN)
		begin
			next_y = pos.y + DESCEND;  // Drop and turn right
			next_right = 1'b1;
		end
		// Move in the new direction
		if (next_right)
			next_x = pos.x + speed;
		else
			next_x = pos.x - speed;
	end

	always_ff @(posedge Clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			pos.x      <= X_START;
			pos.y      <= start_y;
			move_right <= 1'b1;
		end
		else if (cmd == wave_reset)
		begin
			pos.x      <= X_START;  // Restart the wave
			pos.y      <= start_y;
			move_right <= 1'b1;
		end
		else if (cmd == wave_play && step && !landed)
		begin
			pos.x      <= next_x;
			pos.y      <= next_y;
			move_right <= next_right;
		end
		// Hold or landed keeps everything
	end

	assign row_bottom = 11'(pos.y) + 11'(ALIEN_H);
	assign landed = row_bottom >= 11'(LAND_Y);

	// Bounce logic keeps the row near the playfield
	a_x_range: assert property (
		@(posedge Clk) disable iff (!arst_n)
		pos.x >= X_LOW_BOUND && pos.x <= X_MAX
	) else $error("row x %0d outside the playfield", pos.x);

	// A landed row is frozen until the next restart
	a_landed_frozen: assert property (
		@(posedge Clk) disable iff (!arst_n)
		landed && cmd != wave_reset |=> $stable(pos)
	) else $error("landed row moved");

endmodule

// File: source/row_renderer.sv
/*
	Row renderer
	Per-pixel hit test for the seven aliens of one row, giving the alien
	index and the sprite address with the arms-up edge columns
*/
`timescale 1ns/1ps

module row_renderer (
	input  wave_types_pkg::row_pos_t     pos,     // Row top left corner
	input  logic                         arm_up,  // Animation frame select
	input  wave_geometry_pkg::coord_t    draw_x,  // Pixel being drawn
	input  wave_geometry_pkg::coord_t    draw_y,
	output wave_types_pkg::alien_pixel_t pixel
);

	import wave_geometry_pkg::*;
	import wave_types_pkg::*;

	coord_t off;     // Pixel x relative to the row and wrapping high left of it
	coord_t row_dy;  // Pixel y relative to the row
	logic   in_row;  // Inside the row bounding box

	assign off = draw_x - pos.x;
	assign row_dy = draw_y - pos.y;
	// Wrapped values land far above the limits
	assign in_row = (row_dy < ALIEN_H) && (off < ROW_W);

	always_comb
	begin
		coord_t cell_lo;   // Left edge of the alien cell under test
		coord_t col;       // Column inside the sprite
		logic   in_cell;

		pixel = '0;  // Background
		cell_lo = '0;
		col = '0;
		in_cell = 1'b0;
		if (in_row)
		begin
			// Cells do not overlap so at most one matches
			for (int i = 0; i < ALIENS_PER_ROW; i++)
			begin
				cell_lo = coord_t'(i) * ALIEN_PITCH;
				if (off >= cell_lo && off < cell_lo + ALIEN_W)
				begin
					in_cell = 1'b1;
					pixel.index = alien_idx_t'(i);
					col = off - cell_lo;
				end
			end
		end

		if (in_cell)
		begin
			pixel.hit = 1'b1;
			// Row major inside one 21 x 16 frame
			pixel.addr = sprite_addr_t'(row_dy) * sprite_addr_t'(ALIEN_W)
				+ sprite_addr_t'(col);
			if (arm_up && (col <= ARM_LEFT_COL || col >= ARM_RIGHT_COL))
				pixel.addr = pixel.addr + ARM_FRAME_OFS;  // Raised arms
		end

		// A hit names a real alien and stays within the two sprite frames
		if (pixel.hit)
		begin
			a_hit_valid: assert (pixel.index < ALIENS_PER_ROW
				&& pixel.addr < 2 * ARM_FRAME_OFS)
				else $error("bad hit index %0d addr %0d", pixel.index, pixel.addr);
		end
	end

endmodule

// File: source/alien_wave.sv
/*
	Alien wave top level
	One frame pacer shared by the top and lower marching rows, each with
	its own mover and renderer, and the combined landing flag
*/
`timescale 1ns/1ps

module alien_wave #(
	parameter wave_geometry_pkg::coord_t TOP_ROW_Y = 10'd0,   // Upper row start
	parameter wave_geometry_pkg::coord_t LOW_ROW_Y = 10'd60   // Lower row start
) (
	input  logic                         Clk,
	input  logic                         arst_n,
	input  logic                         frame_clk,  // Slow frame strobe
	input  wave_types_pkg::wave_cmd_t    cmd,        // From the game FSM
	input  wave_geometry_pkg::coord_t    draw_x,     // From the VGA controller
	input  wave_geometry_pkg::coord_t    draw_y,
	output wave_types_pkg::row_pos_t     top_pos,
	output wave_types_pkg::row_pos_t     low_pos,
	output wave_types_pkg::alien_pixel_t top_pixel,
	output wave_types_pkg::alien_pixel_t low_pixel,
	output logic                         invaded     // Some row has landed
);

	logic step;        // Shared advance pulse
	logic arm_up;      // Shared animation frame
	logic top_landed;
	logic low_landed;

	// Both rows march in lock step
	frame_pacer u_pacer (
		.Clk       (Clk),
		.arst_n    (arst_n),
		.frame_clk (frame_clk),
		.step      (step),
		.arm_up    (arm_up)
	);

	row_mover #(.start_y(TOP_ROW_Y)) u_top_mover (
		.Clk    (Clk),
		.arst_n (arst_n),
		.cmd    (cmd),
		.step   (step),
		.pos    (top_pos),
		.landed (top_landed)
	);

	row_mover #(.start_y(LOW_ROW_Y)) u_low_mover (
		.Clk    (Clk),
		.arst_n (arst_n),
		.cmd    (cmd),
		.step   (step),
		.pos    (low_pos),
		.landed (low_landed)
	);

	// Hit test against the current draw position
	row_renderer u_top_render (
		.pos    (top_pos),
		.arm_up (arm_up),
		.draw_x (draw_x),
		.draw_y (draw_y),
		.pixel  (top_pixel)
	);

	row_renderer u_low_render (
		.pos    (low_pos),
		.arm_up (arm_up),
		.draw_x (draw_x),
		.draw_y (draw_y),
		.pixel  (low_pixel)
	);

	assign invaded = top_landed | low_landed;  // Either row ends the game

endmodule

// File: verification/alien_wave_tb.sv
/*
	Alien wave testbench
	Marches both rows through play, hold, restart, speed tiers and landing
	against a reference model, with random pixel probes around each row
*/
`timescale 1ns/1ps

module alien_wave_tb;

	import wave_geometry_pkg::*;
	import wave_types_pkg::*;

	localparam coord_t TOP_Y = 10'd0;   // Upper row start height
	localparam coord_t LOW_Y = 10'd60;  // Lower row start height

	logic         Clk;
	logic         arst_n;
	logic         frame_clk;
	wave_cmd_t    cmd;
	coord_t       draw_x;
	coord_t       draw_y;
	row_pos_t     top_pos;
	row_pos_t     low_pos;
	alien_pixel_t top_pixel;
	alien_pixel_t low_pixel;
	logic         invaded;

	// Reference model state
	row_pos_t m_top;
	row_pos_t m_low;
	logic     m_top_right;  // Direction with 1 for right
	logic     m_low_right;
	int       edge_cnt;     // Frame strobe rises since reset
	coord_t   prev_low_x;   // Lower row x before the last edge
	integer   seed;

	// Expected values sampled by the assertions below
	row_pos_t     exp_top;
	row_pos_t     exp_low;
	logic         exp_invaded;
	alien_pixel_t exp_top_pix;
	alien_pixel_t exp_low_pix;
	int           exp_dx;
	int           tier_speed;  // Lower row pixels per step in the current tier
	int           low_dx;
	logic         chk_pos;  // Compare positions on the next edge
	logic         chk_pix;  // Compare pixel outputs on the next edge
	logic         chk_dx;   // Compare the lower row x step
	logic         dx_on;
	string        test_name;

	alien_wave #(
		.TOP_ROW_Y (TOP_Y),
		.LOW_ROW_Y (LOW_Y)
	) DUT (
		.Clk       (Clk),
		.arst_n    (arst_n),
		.frame_clk (frame_clk),
		.cmd       (cmd),
		.draw_x    (draw_x),
		.draw_y    (draw_y),
		.top_pos   (top_pos),
		.low_pos   (low_pos),
		.top_pixel (top_pixel),
		.low_pixel (low_pixel),
		.invaded   (invaded)
	);

	always #10 Clk = ~Clk;  // 20 ns period

	assign low_dx = int'(low_pos.x) - int'(prev_low_x);  // Signed x change

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	a_top_pos: assert property (@(posedge Clk) chk_pos |-> top_pos == exp_top)
		else stop_on_error($sformatf(
			"CHECK FAILED %s: top_pos expected (%0d,%0d) actual (%0d,%0d)",
			test_name, exp_top.x, exp_top.y, top_pos.x, top_pos.y));

	a_low_pos: assert property (@(posedge Clk) chk_pos |-> low_pos == exp_low)
		else stop_on_error($sformatf(
			"CHECK FAILED %s: low_pos expected (%0d,%0d) actual (%0d,%0d)",
			test_name, exp_low.x, exp_low.y, low_pos.x, low_pos.y));

	a_invaded: assert property (@(posedge Clk) chk_pos |-> invaded == exp_invaded)
		else stop_on_error($sformatf("CHECK FAILED %s: invaded expected %0d actual %0d",
			test_name, exp_invaded, invaded));

	a_low_step: assert property (@(posedge Clk) chk_dx |-> low_dx == exp_dx)
		else stop_on_error($sformatf("CHECK FAILED %s: low row x step expected %0d actual %0d",
			test_name, exp_dx, low_dx));

	a_top_pixel: assert property (@(posedge Clk) chk_pix |-> top_pixel == exp_top_pix)
		else stop_on_error($sformatf(
			"CHECK FAILED %s: top_pixel at (%0d,%0d) expected %0d/%0d/%0d actual %0d/%0d/%0d",
			test_name, draw_x, draw_y, exp_top_pix.hit, exp_top_pix.index, exp_top_pix.addr,
			top_pixel.hit, top_pixel.index, top_pixel.addr));

	a_low_pixel: assert property (@(posedge Clk) chk_pix |-> low_pixel == exp_low_pix)
		else stop_on_error($sformatf(
			"CHECK FAILED %s: low_pixel at (%0d,%0d) expected %0d/%0d/%0d actual %0d/%0d/%0d",
			test_name, draw_x, draw_y, exp_low_pix.hit, exp_low_pix.index, exp_low_pix.addr,
			low_pixel.hit, low_pixel.index, low_pixel.addr));

	// Pixels per step from the height before the step
	function automatic int speed_for(input coord_t y);
		if (y > SPEED3_Y)
			return 3;
		else if (y > SPEED2_Y)
			return 2;
		return 1;
	endfunction

	function automatic logic has_landed(input row_pos_t p);
		return (int'(p.y) + int'(ALIEN_H)) >= int'(LAND_Y);
	endfunction

	// Upper half of every 32 frames shows raised arms
	function automatic logic arms_raised();
		return (edge_cnt % 32) >= 16;
	endfunction

	// Hit test by cell arithmetic
	function automatic alien_pixel_t expected_pixel(input row_pos_t p, input coord_t px,
		input coord_t py);
		alien_pixel_t res;
		coord_t       off;
		coord_t       dy;
		int           col;

		res = '0;
		off = px - p.x;  // Wraps high when left of the row
		dy = py - p.y;
		col = int'(off) % int'(ALIEN_PITCH);
		if (dy < ALIEN_H && off < ROW_W && col < int'(ALIEN_W))
		begin
			res.hit = 1'b1;
			res.index = alien_idx_t'(int'(off) / int'(ALIEN_PITCH));
			res.addr = sprite_addr_t'(int'(dy) * int'(ALIEN_W) + col);
			if (arms_raised() && (col <= 2 || col >= 18))
				res.addr = res.addr + ARM_FRAME_OFS;  // Second sprite frame
		end
		return res;
	endfunction

	task automatic reset_model();
		m_top.x = X_START;
		m_top.y = TOP_Y;
		m_low.x = X_START;
		m_low.y = LOW_Y;
		m_top_right = 1'b1;
		m_low_right = 1'b1;
		prev_low_x = X_START;
		exp_dx = 0;
	endtask

	// One marching step of a model row
	task automatic step_row(inout row_pos_t p, inout logic go_right);
		int speed;

		if (!has_landed(p))
		begin
			speed = speed_for(p.y);
			if (p.x >= X_MAX - ROW_W)
			begin
				p.y = p.y + DESCEND;  // Right limit
				go_right = 1'b0;
			end
			else if (p.x <= X_MIN)
			begin
				p.y = p.y + DESCEND;  // Left limit
				go_right = 1'b1;
			end
			p.x = go_right ? p.x + coord_t'(speed) : p.x - coord_t'(speed);
		end
	endtask

	task automatic advance_model();
		prev_low_x = m_low.x;
		exp_dx = 0;
		if (cmd == wave_play && edge_cnt % 2 == 1)  // Odd edges only
		begin
			step_row(m_top, m_top_right);
			step_row(m_low, m_low_right);
			exp_dx = m_low_right ? tier_speed : -tier_speed;  // Tier speed in the new direction
		end
	endtask

	// Arms one position check for the next rising edge
	task automatic check_positions();
		exp_top = m_top;
		exp_low = m_low;
		exp_invaded = has_landed(m_top) | has_landed(m_low);
		chk_pos = 1'b1;
		chk_dx = dx_on;
		@(negedge Clk);
		chk_pos = 1'b0;
		chk_dx = 1'b0;
	endtask

	task automatic probe_at(input coord_t px, input coord_t py);
		draw_x = px;
		draw_y = py;
		exp_top_pix = expected_pixel(m_top, px, py);
		exp_low_pix = expected_pixel(m_low, px, py);
		chk_pix = 1'b1;
		@(negedge Clk);
		chk_pix = 1'b0;
	endtask

	// Random pixel near one of the rows
	task automatic random_probe();
		row_pos_t p;
		coord_t   px;
		coord_t   py;

		p = ({$random(seed)} % 2 == 0) ? m_top : m_low;
		px = coord_t'(int'(p.x) - 10 + int'({$random(seed)} % 222));
		py = coord_t'(int'(p.y) - 2 + int'({$random(seed)} % 20));
		probe_at(px, py);
	endtask

	// One 8 Clk frame with the strobe high for the first 4 Clk
	task automatic run_frame();
		frame_clk = 1'b1;
		edge_cnt++;
		advance_model();
		repeat (3) @(negedge Clk);
		check_positions();  // Sampled 4 Clk after the rise
		frame_clk = 1'b0;
		random_probe();
		random_probe();
		repeat (2) @(negedge Clk);
	endtask

	// New command checked within 2 Clk
	task automatic set_cmd(input wave_cmd_t c);
		cmd = c;
		if (c == wave_reset)
			reset_model();
		@(negedge Clk);
		check_positions();
	endtask

	initial
	begin
		int n;

		Clk = 1'b0;
		arst_n = 1'b0;
		frame_clk = 1'b0;
		cmd = wave_reset;
		draw_x = '0;
		draw_y = '0;
		chk_pos = 1'b0;
		chk_pix = 1'b0;
		chk_dx = 1'b0;
		dx_on = 1'b0;
		tier_speed = 1;
		edge_cnt = 0;
		seed = 32'h9f1c;
		exp_top = '0;
		exp_low = '0;
		exp_invaded = 1'b0;
		exp_top_pix = '0;
		exp_low_pix = '0;
		test_name = "reset";
		reset_model();
		repeat (8) @(negedge Clk);
		arst_n = 1'b1;

		// Start positions and a few fixed pixels
		test_name = "after reset";
		@(negedge Clk);
		check_positions();
		probe_at(10'd169, 10'd5);   // Just left of the row
		probe_at(10'd170, 10'd0);   // First alien, top left
		probe_at(10'd370, 10'd75);  // Last alien of the lower row
		set_cmd(wave_play);

		// March until the lower row bounces off the right limit
		test_name = "marching";
		n = 0;
		while (m_low_right && n < 600)
		begin
			run_frame();
			n++;
		end
		if (m_low_right)
			stop_on_error("marching: lower row never reached the right limit");
		repeat (6) run_frame();

		// Frozen rows, then restart
		test_name = "hold";
		set_cmd(wave_hold);
		repeat (6) run_frame();
		test_name = "restart";
		set_cmd(wave_reset);
		run_frame();
		set_cmd(wave_play);

		// Speed tiers by height of the lower row
		test_name = "speed tier 2";
		n = 0;
		while (m_low.y <= SPEED2_Y && n < 800)
		begin
			run_frame();
			n++;
		end
		if (m_low.y <= SPEED2_Y)
			stop_on_error("speed tier 2: lower row never passed y 65");
		tier_speed = 2;
		dx_on = 1'b1;
		repeat (8) run_frame();
		dx_on = 1'b0;
		test_name = "speed tier 3";
		n = 0;
		while (m_low.y <= SPEED3_Y && n < 8000)
		begin
			run_frame();
			n++;
		end
		if (m_low.y <= SPEED3_Y)
			stop_on_error("speed tier 3: lower row never passed y 240");
		tier_speed = 3;
		dx_on = 1'b1;
		repeat (8) run_frame();
		dx_on = 1'b0;

		// Lower row lands while the top row keeps going
		test_name = "landing";
		n = 0;
		while (!has_landed(m_low) && n < 8000)
		begin
			run_frame();
			n++;
		end
		if (!has_landed(m_low))
			stop_on_error("landing: lower row never reached the ground");
		if (has_landed(m_top))
			stop_on_error("landing: top row landed before the lower row");
		repeat (10) run_frame();

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

// File: project.f
source/wave_geometry_pkg.sv
source/wave_types_pkg.sv
source/frame_pacer.sv
source/row_mover.sv
source/row_renderer.sv
source/alien_wave.sv
verification/alien_wave_tb.sv

// File: Makefile
# Verilator build and run of the alien wave testbench

VERILATOR ?= verilator
TOP       ?= alien_wave_tb
FLIST     ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FLIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf $(OBJ_DIR)
